/* design/dds_pkg.sv */
package dds_pkg;

	//////////////////////////////////////////////////
	// payload widths
	//////////////////////////////////////////////////

	localparam int FREQ_W  = 48;	// frequency tuning word
	localparam int PHASE_W = 14;	// phase offset
	localparam int AMP_W   = 10;	// amplitude scale

	//////////////////////////////////////////////////
	// instruction word layout
	//////////////////////////////////////////////////

	localparam int INSTR_W = 64;	// 16 bit header + 48 bit payload
	localparam int SHORT_W = 32;	// 16 bit header + 16 bit payload

	// register addresses, 13 bit
	localparam logic [12:0] FREQ_ADDR  = 13'h01AB;
	localparam logic [12:0] PHASE_ADDR = 13'h01AD;
	localparam logic [12:0] AMP_ADDR   = 13'h040C;

	// width codes in the header
	localparam logic [1:0] WC_LONG  = 2'b11;	// 48 bit payload
	localparam logic [1:0] WC_SHORT = 2'b01;	// 16 bit payload

	//////////////////////////////////////////////////
	// timing, in clk_in cycles
	//////////////////////////////////////////////////

	localparam int IO_UPDATE_CYCLES = 4;	// io_update high time
	localparam int UPDATE_LATENCY   = 5;	// chip update latency after io_update

endpackage

/* design/dds_cmd_builder.sv */
`timescale 1ns/10ps

module dds_cmd_builder (
	input  logic                        clk_in,
	input  logic                        reset_in,
	input  logic [dds_pkg::FREQ_W-1:0]  freq,
	input  logic                        freq_valid,
	output logic                        freq_ready,
	input  logic [dds_pkg::PHASE_W-1:0] phase,
	input  logic                        phase_valid,
	output logic                        phase_ready,
	input  logic [dds_pkg::AMP_W-1:0]   amp,
	input  logic                        amp_valid,
	output logic                        amp_ready,
	input  logic                        tx_enable,
	input  logic                        cmd_ready,
	output logic                        cmd_valid,
	output logic [dds_pkg::INSTR_W-1:0] cmd_word,
	output logic                        cmd_long,
	output logic                        any_pending
);
	import dds_pkg::*;

	logic [FREQ_W-1:0]  freq_q;		// held values
	logic [PHASE_W-1:0] phase_q;
	logic [AMP_W-1:0]   amp_q;
	logic freq_pend, phase_pend, amp_pend;	// value waiting for the chip
	logic [INSTR_W-1:0] freq_word, phase_word, amp_word;
	logic [INSTR_W-1:0] next_word;	// highest priority word
	logic               next_long;
	logic [2:0]         next_sel;	// one-hot {amp, phase, freq}
	logic [2:0]         sel_q;	// source of the word on offer
	logic               cmd_take;

	assign freq_ready  = ~freq_pend;	// one slot per parameter
	assign phase_ready = ~phase_pend;
	assign amp_ready   = ~amp_pend;
	assign any_pending = freq_pend | phase_pend | amp_pend;
	assign cmd_take    = cmd_valid & cmd_ready;

	//////////////////////////////////////////////////
	// instruction words
	//////////////////////////////////////////////////

	assign freq_word  = {1'b0, WC_LONG, FREQ_ADDR, freq_q};
	assign phase_word = {1'b0, WC_SHORT, PHASE_ADDR, 16'(phase_q),
		{(INSTR_W-SHORT_W){1'b0}}};	// left aligned
	assign amp_word   = {1'b0, WC_SHORT, AMP_ADDR, 16'(amp_q),
		{(INSTR_W-SHORT_W){1'b0}}};

	always_comb begin	// freq over phase over amp
		next_word = amp_word;
		next_long = 1'b0;
		next_sel  = 3'b100;
		if (freq_pend) begin
			next_word = freq_word;
			next_long = 1'b1;
			next_sel  = 3'b001;
		end else if (phase_pend) begin
			next_word = phase_word;
			next_sel  = 3'b010;
		end
	end

	always_ff @(posedge clk_in) begin	// value capture on handshake
		if (freq_valid && freq_ready)
			freq_q <= freq;
		if (phase_valid && phase_ready)
			phase_q <= phase;
		if (amp_valid && amp_ready)
			amp_q <= amp;
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			freq_pend  <= 1'b0;
			phase_pend <= 1'b0;
			amp_pend   <= 1'b0;
			cmd_valid  <= 1'b0;
		end else begin
			if (freq_valid && freq_ready)
				freq_pend <= 1'b1;
			else if (cmd_take && sel_q[0])
				freq_pend <= 1'b0;	// released once the shifter has it
			if (phase_valid && phase_ready)
				phase_pend <= 1'b1;
			else if (cmd_take && sel_q[1])
				phase_pend <= 1'b0;
			if (amp_valid && amp_ready)
				amp_pend <= 1'b1;
			else if (cmd_take && sel_q[2])
				amp_pend <= 1'b0;
			if (cmd_take)
				cmd_valid <= 1'b0;	// one idle cycle between words
			else if (!cmd_valid && tx_enable && any_pending)
				cmd_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin	// word frozen while offered
		if (!cmd_valid) begin
			cmd_word <= next_word;
			cmd_long <= next_long;
			sel_q    <= next_sel;
		end
	end

endmodule

/* design/dds_spi_shifter.sv */
`timescale 1ns/10ps

module dds_spi_shifter (
	input  logic                        clk_in,
	input  logic                        reset_in,
	input  logic                        cmd_valid,
	output logic                        cmd_ready,
	input  logic [dds_pkg::INSTR_W-1:0] cmd_word,
	input  logic                        cmd_long,
	output logic                        busy,
	output logic                        sclk,
	output logic                        csb,
	output logic                        sdio
);
	import dds_pkg::*;

	typedef enum logic [1:0] {
		SH_IDLE,
		SH_SHIFT,
		SH_GUARD
	} sh_state_t;

	sh_state_t          state;
	logic [INSTR_W-1:0] sreg;	// msb goes out first
	logic [5:0]         bits_left;	// bits after the current one
	logic               guard_cnt;	// two cycle gap

	assign cmd_ready = (state == SH_IDLE);
	assign busy      = (state != SH_IDLE);
	assign sdio      = sreg[INSTR_W-1] & ~csb;	// quiet outside a word

	//////////////////////////////////////////////////
	// control: csb, sclk phase, bit count
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state     <= SH_IDLE;
			csb       <= 1'b1;
			sclk      <= 1'b0;
			bits_left <= '0;
			guard_cnt <= 1'b0;
		end else begin
			case (state)
				SH_IDLE: begin
					if (cmd_valid) begin
						state     <= SH_SHIFT;
						csb       <= 1'b0;	// low the cycle after accept
						sclk      <= 1'b0;
						bits_left <= cmd_long ? 6'(INSTR_W-1) : 6'(SHORT_W-1);
					end
				end
				SH_SHIFT: begin
					sclk <= ~sclk;	// half rate
					if (sclk) begin	// end of the high half
						if (bits_left == '0) begin
							state     <= SH_GUARD;
							csb       <= 1'b1;
							sclk      <= 1'b0;
							guard_cnt <= 1'b0;
						end else begin
							bits_left <= bits_left - 6'd1;
						end
					end
				end
				SH_GUARD: begin
					guard_cnt <= 1'b1;
					if (guard_cnt)
						state <= SH_IDLE;
				end
				default: state <= SH_IDLE;
			endcase
		end
	end

	// data path: load on accept, shift as sclk falls
	always_ff @(posedge clk_in) begin
		if (state == SH_IDLE && cmd_valid)
			sreg <= cmd_word;
		else if (state == SH_SHIFT && sclk)
			sreg <= {sreg[INSTR_W-2:0], 1'b0};	// next bit while sclk low
	end

endmodule

/* design/dds_update_seq.sv */
`timescale 1ns/10ps

module dds_update_seq (
	input  logic clk_in,
	input  logic reset_in,
	input  logic any_pending,
	input  logic shifter_busy,
	output logic tx_enable,
	output logic io_update,
	output logic done
);
	import dds_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_BATCH,
		ST_UPDATE,
		ST_WAIT,
		ST_DONE
	} seq_state_t;

	seq_state_t state;
	logic [2:0] cnt;	// shared by update and wait

	//////////////////////////////////////////////////
	// outputs, straight state decode
	//////////////////////////////////////////////////

	assign tx_enable = (state == ST_BATCH);	// builder may offer words
	assign io_update = (state == ST_UPDATE);
	assign done      = (state == ST_DONE);	// single cycle

	//////////////////////////////////////////////////
	// batch FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= ST_IDLE;
			cnt   <= '0;
		end else begin
			cnt <= cnt + 3'd1;	// free running, cleared on entry
			case (state)
				ST_IDLE: begin
					if (any_pending)
						state <= ST_BATCH;
				end
				ST_BATCH: begin
					// late arrivals keep the batch open
					if (!any_pending && !shifter_busy) begin
						state <= ST_UPDATE;
						cnt   <= '0;
					end
				end
				ST_UPDATE: begin
					if (cnt == 3'(IO_UPDATE_CYCLES-1)) begin
						state <= ST_WAIT;
						cnt   <= '0;
					end
				end
				ST_WAIT: begin
					// latency plus one cycle after io_update drops
					if (cnt == 3'(UPDATE_LATENCY))
						state <= ST_DONE;
				end
				ST_DONE: begin
					state <= ST_IDLE;	// back for the next batch
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* design/dds_top.sv */
`timescale 1ns/10ps

module dds_top (
	input  logic                        clk_in,
	input  logic                        reset_in,
	input  logic [dds_pkg::FREQ_W-1:0]  freq,
	input  logic                        freq_valid,
	output logic                        freq_ready,
	input  logic [dds_pkg::PHASE_W-1:0] phase,
	input  logic                        phase_valid,
	output logic                        phase_ready,
	input  logic [dds_pkg::AMP_W-1:0]   amp,
	input  logic                        amp_valid,
	output logic                        amp_ready,
	output logic                        sclk,
	output logic                        csb,
	output logic                        sdio,
	output logic                        io_update,
	output logic                        dds_reset,
	output logic                        done
);
	import dds_pkg::*;

	logic               cmd_valid, cmd_ready, cmd_long;
	logic [INSTR_W-1:0] cmd_word;
	logic               any_pending, tx_enable, shifter_busy;

	always_ff @(posedge clk_in) begin
		dds_reset <= reset_in;	// chip reset, one register
	end

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	dds_cmd_builder u_builder (
		.clk_in, .reset_in,
		.freq, .freq_valid, .freq_ready,
		.phase, .phase_valid, .phase_ready,
		.amp, .amp_valid, .amp_ready,
		.tx_enable, .cmd_ready, .cmd_valid, .cmd_word, .cmd_long,
		.any_pending
	);

	dds_spi_shifter u_shifter (
		.clk_in, .reset_in,
		.cmd_valid, .cmd_ready, .cmd_word, .cmd_long,
		.busy (shifter_busy),	// guard gap included
		.sclk, .csb, .sdio
	);

	dds_update_seq u_seq (
		.clk_in, .reset_in,
		.any_pending, .shifter_busy,
		.tx_enable, .io_update, .done
	);

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_in,
	output logic reset_in
);
	initial begin
		clk_in = 1'b0;
		forever #5 clk_in = ~clk_in;	// 10 ns period
	end

	initial begin
		reset_in = 1'b1;
		repeat (5) @(posedge clk_in);	// five cycles in reset
		#1 reset_in = 1'b0;	// off the edge, like the other inputs
	end

endmodule

/* test/dds_assert.sv */
`timescale 1ns/10ps

module dds_assert (
	input logic clk_in,
	input logic reset_in,
	input logic sclk,
	input logic csb,
	input logic io_update,
	input logic done
);
	import dds_pkg::*;

	logic       csb_q, upd_q, done_q;	// previous cycle
	logic [7:0] low_len;	// cycles with csb low
	logic [3:0] upd_len;	// cycles with io_update high

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			csb_q   <= 1'b1;
			upd_q   <= 1'b0;
			done_q  <= 1'b0;
			low_len <= '0;
			upd_len <= '0;
		end else begin
			csb_q   <= csb;
			upd_q   <= io_update;
			done_q  <= done;
			low_len <= csb ? 8'd0 : low_len + 8'd1;
			upd_len <= io_update ? upd_len + 4'd1 : 4'd0;
		end
	end

	csb_even: assert property (@(posedge clk_in) disable iff (reset_in)
		(csb && !csb_q) |-> !low_len[0])
		else $error("csb was low for an odd number of cycles");
	sclk_idle: assert property (@(posedge clk_in) disable iff (reset_in) csb |-> !sclk)
		else $error("sclk high while csb is high");
	upd_width: assert property (@(posedge clk_in) disable iff (reset_in)
		(!io_update && upd_q) |-> (upd_len == 4'(IO_UPDATE_CYCLES)))
		else $error("io_update pulse has the wrong length");
	done_width: assert property (@(posedge clk_in) disable iff (reset_in) done |-> !done_q)
		else $error("done lasted more than one cycle");

endmodule

/* test/tb_dds_top.sv */
`timescale 1ns/10ps

module tb_dds_top;
	import dds_pkg::*;

	localparam int N_ROWS = 10;	// five fixed rows, five random

	logic clk_in, reset_in, sclk, csb, sdio, io_update, dds_reset, done;
	logic [FREQ_W-1:0]  freq;
	logic [PHASE_W-1:0] phase;
	logic [AMP_W-1:0]   amp;
	logic freq_valid, phase_valid, amp_valid, freq_ready, phase_ready, amp_ready;

	string              row_name [N_ROWS];
	logic [3:0]         row_mask [N_ROWS];	// {second freq, amp, phase, freq}
	logic [FREQ_W-1:0]  row_freq [N_ROWS];
	logic [FREQ_W-1:0]  row_freq2 [N_ROWS];	// offered while the first is pending
	logic [PHASE_W-1:0] row_phase [N_ROWS];
	logic [AMP_W-1:0]   row_amp [N_ROWS];
	int                 row_gap [N_ROWS];	// cycles before the next row
	int                 row_words [N_ROWS];	// expected word count

	logic [63:0] got_word [$], exp_word [$], shift_acc;
	int          got_len [$], exp_len [$];
	int          bit_cnt, done_cnt, upd_cnt, val_errs, misc_errs;
	logic [15:0] lfsr;
	time         upd_fall_t, done_rise_t;	// io_update to done latency

	tb_clock_gen u_clk (.clk_in, .reset_in);
	dds_top DUT (.*);
	bind dds_top dds_assert u_assert (.clk_in, .reset_in, .sclk, .csb, .io_update, .done);

	//////////////////////////////////////////////////
	// serial port decoder and pulse counters
	//////////////////////////////////////////////////

	always @(negedge csb) begin
		shift_acc = '0;	// new word
		bit_cnt = 0;
	end
	always @(posedge sclk) begin
		if (!csb) begin
			shift_acc = {shift_acc[62:0], sdio};	// chip samples on rising sclk
			bit_cnt++;
		end
	end
	always @(posedge csb) begin
		if (!reset_in) begin
			got_word.push_back(shift_acc);
			got_len.push_back(bit_cnt);
		end
	end
	always @(posedge done) done_cnt++;
	always @(posedge io_update) upd_cnt++;
	always @(negedge io_update) upd_fall_t = $time;
	always @(posedge done) done_rise_t = $time;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);	// galois, x^16+x^14+x^13+x^11+1
	endfunction

	task automatic rand_bits(int n, output logic [FREQ_W-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);	// one step per bit
			v = {v[FREQ_W-2:0], lfsr[0]};
		end
	endtask

	task automatic set_row(int r, string name, logic [3:0] m, logic [FREQ_W-1:0] f,
		logic [FREQ_W-1:0] f2, logic [PHASE_W-1:0] p, logic [AMP_W-1:0] a, int gap);
		row_name[r]  = name;
		row_mask[r]  = m;
		row_freq[r]  = f;
		row_freq2[r] = f2;
		row_phase[r] = p;
		row_amp[r]   = a;
		row_gap[r]   = gap;
		row_words[r] = $countones(m);
	endtask

	task automatic check_val(string name, logic [63:0] exp, logic [63:0] got);
		assert (exp === got) else begin
			$display("** Error: %s: expected %h, actual %h", name, exp, got);
			val_errs++;
		end
	endtask

	task automatic check_true(string name, bit ok, string what);
		assert (ok) else begin
			$display("%s: %s", name, what);
			misc_errs++;
		end
	endtask

	// holds each valid until its ready, called 1 ns after an edge
	task automatic offer(logic [2:0] sel, logic [FREQ_W-1:0] f, logic [PHASE_W-1:0] p,
		logic [AMP_W-1:0] a, output int stalls);
		logic [2:0] ack;
		stalls = 0;
		freq = f;
		phase = p;
		amp = a;
		{amp_valid, phase_valid, freq_valid} = sel;
		while (freq_valid || phase_valid || amp_valid) begin
			ack = {amp_valid & amp_ready, phase_valid & phase_ready, freq_valid & freq_ready};
			@(posedge clk_in);
			#1;
			{amp_valid, phase_valid, freq_valid} = {amp_valid, phase_valid, freq_valid} & ~ack;
			if (ack == 3'b000)
				stalls++;	// back-pressure cycle
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int stalls;
		int start_done;
		int start_upd;
		int wait_cyc;
		logic [FREQ_W-1:0] v;
		logic [FREQ_W-1:0] f;
		freq = '0;
		phase = '0;
		amp = '0;
		{freq_valid, phase_valid, amp_valid} = 3'b000;
		{done_cnt, upd_cnt, val_errs, misc_errs} = '0;
		lfsr = 16'd63911;
		set_row(0, "freq_only", 4'b0001, 48'h1234_5678_9ABC, '0, '0, '0, 4);
		set_row(1, "all_three", 4'b0111, 48'hFEDC_BA98_7654, '0, 14'h3FFF, 10'h3FF, 4);
		set_row(2, "phase_only", 4'b0010, '0, '0, 14'h1234, '0, 3);
		set_row(3, "amp_only", 4'b0100, '0, '0, '0, 10'h2A5, 3);
		set_row(4, "back_pressure", 4'b1001, 48'h0000_0000_0001, 48'hAAAA_5555_0F0F, '0, '0, 4);
		for (int r = 5; r < N_ROWS; r++) begin
			rand_bits(3, v);
			rand_bits(FREQ_W, f);	// mask, then values
			set_row(r, $sformatf("random_%0d", r), {1'b0, (v[2:0] == 3'b000) ? 3'b111 : v[2:0]},
				f, '0, f[PHASE_W-1:0], f[FREQ_W-1 -: AMP_W], 3);
		end
		@(posedge clk_in);
		#1;
		check_true("in_reset", dds_reset === 1'b1, "dds_reset low while reset_in is high");
		@(negedge reset_in);
		repeat (2) @(posedge clk_in);
		#1;
		check_true("after_reset", csb && !sclk && !sdio && !io_update && !done && !dds_reset
			&& freq_ready && phase_ready && amp_ready, "outputs not at their reset values");
		for (int r = 0; r < N_ROWS; r++) begin
			start_done = done_cnt;
			start_upd = upd_cnt;
			if (row_mask[r][0]) exp_word.push_back({1'b0, WC_LONG, FREQ_ADDR, row_freq[r]});
			if (row_mask[r][3]) exp_word.push_back({1'b0, WC_LONG, FREQ_ADDR, row_freq2[r]});
			if (row_mask[r][1])
				exp_word.push_back({33'h0, WC_SHORT, PHASE_ADDR, 2'b00, row_phase[r]});
			if (row_mask[r][2])
				exp_word.push_back({33'h0, WC_SHORT, AMP_ADDR, 6'h00, row_amp[r]});
			foreach (exp_word[i]) exp_len.push_back(exp_word[i][63:32] != 0 ? 64 : 32);
			offer(row_mask[r][2:0], row_freq[r], row_phase[r], row_amp[r], stalls);
			if (row_mask[r][3]) begin	// second value joins the open batch
				check_true(row_name[r], !freq_ready, "freq_ready high while a value is pending");
				offer(3'b001, row_freq2[r], '0, '0, stalls);
				check_true(row_name[r], stalls > 0, "second value taken without back-pressure");
			end
			wait_cyc = 0;
			while (done_cnt == start_done && wait_cyc < 400) begin
				@(posedge clk_in);
				wait_cyc++;
			end
			check_true(row_name[r], done_cnt != start_done, "no done pulse within 400 cycles");
			repeat (row_gap[r]) @(posedge clk_in);
			#1;
			check_true(row_name[r], done_cnt - start_done == 1 && upd_cnt - start_upd == 1,
				"expected exactly one io_update and one done");
			check_true(row_name[r], done_rise_t - upd_fall_t == (UPDATE_LATENCY + 1) * 10,
				"done not at the update latency after io_update fell");
			check_true(row_name[r], got_word.size() == row_words[r], "wrong number of words");
			while (got_word.size() > 0 && exp_word.size() > 0) begin
				check_val(row_name[r], exp_word.pop_front(), got_word.pop_front());
				check_val(row_name[r], 64'(exp_len.pop_front()), 64'(got_len.pop_front()));
			end
			got_word.delete();
			got_len.delete();
			exp_word.delete();
			exp_len.delete();
		end
		$display("rows: %0d, value errors: %0d, other errors: %0d", N_ROWS, val_errs, misc_errs);
		if (val_errs + misc_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin	// watchdog, 400 cycles per row plus margin
		#((N_ROWS * 400 + 500) * 10);
		$display("watchdog: the run did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* dds_ctrl.f */
design/dds_pkg.sv
design/dds_cmd_builder.sv
design/dds_spi_shifter.sv
design/dds_update_seq.sv
design/dds_top.sv
test/tb_clock_gen.sv
test/dds_assert.sv
test/tb_dds_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_dds_top -f dds_ctrl.f
./obj_dir/Vtb_dds_top | tee sim.log
if grep -q "RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
